// ==== tti_pkg.sv ====
// Queue word, fill level and threshold types shared by the TTI queues and the CSR slave
`default_nettype none

package tti_pkg;

  // Width of one queue word, also the Wishbone data width
  localparam int unsigned DataWidth = 32;

  // Default number of words held by each queue
  localparam int unsigned Depth = 8;

  // RX ready threshold field width
  localparam int unsigned ThldWidth = 3;

  // One word as stored in a queue and carried on the bus
  typedef logic [DataWidth-1:0] data_t;

  // Fill level, needs to reach Depth itself
  typedef logic [$clog2(Depth + 1)-1:0] count_t;

  // Software programmed RX ready threshold
  typedef logic [ThldWidth-1:0] thld_t;

endpackage

`default_nettype wire

// ==== tti_csr_pkg.sv ====
// Register offsets, control bit positions, status fields and Wishbone widths of the CSR slave
`default_nettype none

package tti_csr_pkg;

  // Word address width of the Wishbone slave
  localparam int unsigned AdrWidth = 3;

  // Register map, offsets 5 to 7 are unmapped
  typedef enum logic [AdrWidth-1:0] {
    CsrTxData = 3'd0,
    CsrRxData = 3'd1,
    CsrCtrl   = 3'd2,
    CsrThld   = 3'd3,
    CsrStatus = 3'd4
  } csr_adr_e;

  // Control register bits, flushes are self clearing
  localparam int unsigned CtrlRecBit     = 0;
  localparam int unsigned CtrlTxFlushBit = 1;
  localparam int unsigned CtrlRxFlushBit = 2;

  // RX ready threshold field in the threshold register
  localparam int unsigned ThldLsb = 0;

  // Status register layout
  localparam int unsigned StatRxEmptyBit = 0;
  localparam int unsigned StatRxFullBit  = 1;
  localparam int unsigned StatTxEmptyBit = 2;
  localparam int unsigned StatTxFullBit  = 3;
  localparam int unsigned StatRxCntLsb   = 8;
  localparam int unsigned StatTxCntLsb   = 16;

endpackage

`default_nettype wire

// ==== tti_fifo.sv ====
// First-word-fall-through queue with flush and a recovery gated controller-side port
`timescale 1ns/100ps
`default_nettype none

module tti_fifo #(
  parameter int unsigned Depth      = 8,
  parameter bit          CtlOnWrite = 1'b1
) (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            flush_i,
  // High while recovery owns the queue, cuts off the controller side
  input  logic            ctl_en_i,

  input  logic            push_i,
  input  tti_pkg::data_t  wdata_i,
  output logic            wready_o,

  input  logic            pop_i,
  output logic            rvalid_o,
  output tti_pkg::data_t  rdata_o,

  output logic            full_o,
  output logic            empty_o,
  output tti_pkg::count_t count_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam tti_pkg::count_t CountFull = tti_pkg::count_t'(Depth);

  tti_pkg::data_t        mem_q [Depth];
  logic [PtrWidth-1:0]   wr_ptr_q;
  logic [PtrWidth-1:0]   rd_ptr_q;
  tti_pkg::count_t       count_q;

  logic full, empty;
  logic wr_gate, rd_gate;
  logic push_ok, pop_ok;

  function automatic logic [PtrWidth-1:0] next_ptr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(Depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = (count_q == CountFull);
  assign empty = (count_q == '0);

  // Only the controller-facing side is gated
  assign wr_gate = CtlOnWrite && ctl_en_i;
  assign rd_gate = !CtlOnWrite && ctl_en_i;

  assign push_ok = push_i && !full && !wr_gate;
  assign pop_ok  = pop_i && !empty && !rd_gate;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Simultaneous push and pop keep the level
      case ({push_ok, pop_ok})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  assign wready_o = !full && !wr_gate;
  assign rvalid_o = !empty && !rd_gate;
  assign rdata_o  = mem_q[rd_ptr_q];

  // Flags as the controller sees them
  assign full_o  = full && !ctl_en_i;
  assign empty_o = empty && !ctl_en_i;
  assign count_o = count_q;

endmodule

`default_nettype wire

// ==== tti_csr_wb.sv ====
// Wishbone classic CSR slave with data queue access, recovery control, RX threshold and interrupt
`timescale 1ns/100ps
`default_nettype none

module tti_csr_wb #(
  parameter int unsigned Depth = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_i,

  // Wishbone classic slave
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [tti_csr_pkg::AdrWidth-1:0]  wb_adr_i,
  input  tti_pkg::data_t                    wb_dat_i,
  output tti_pkg::data_t                    wb_dat_o,
  output logic                              wb_ack_o,

  // RX queue, software side
  input  tti_pkg::data_t                    rx_rdata_i,
  input  tti_pkg::count_t                   rx_count_i,
  output logic                              rx_pop_o,
  output logic                              rx_flush_o,

  // TX queue, software side
  input  tti_pkg::count_t                   tx_count_i,
  output logic                              tx_push_o,
  output tti_pkg::data_t                    tx_wdata_o,
  output logic                              tx_flush_o,

  output logic                              rec_en_o,
  output logic                              irq_o
);

  localparam tti_pkg::count_t CountFull = tti_pkg::count_t'(Depth);

  tti_csr_pkg::csr_adr_e adr;

  logic            req;
  logic            wr_stall;
  logic            ack_q;
  logic            wr_ack;
  logic            rd_ack;

  logic            rec_q;
  tti_pkg::thld_t  thld_q;

  logic            rx_empty;
  logic            rx_full;
  logic            tx_empty;
  logic            tx_full;

  tti_pkg::data_t  status_word;
  tti_pkg::data_t  ctrl_word;
  tti_pkg::data_t  thld_word;

  assign adr = tti_csr_pkg::csr_adr_e'(wb_adr_i);

  // Queue flags from the raw fill levels
  assign rx_empty = (rx_count_i == '0);
  assign rx_full  = (rx_count_i == CountFull);
  assign tx_empty = (tx_count_i == '0);
  assign tx_full  = (tx_count_i == CountFull);

  // New request only outside the ack cycle, so ack lasts one cycle
  assign req = wb_cyc_i && wb_stb_i && !ack_q;

  // TX write into a full queue waits for a controller pop
  assign wr_stall = wb_we_i && (adr == tti_csr_pkg::CsrTxData) && tx_full && !rec_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req && !wr_stall;
    end
  end

  assign wb_ack_o = ack_q;
  assign wr_ack   = ack_q && wb_we_i;
  assign rd_ack   = ack_q && !wb_we_i;

  // Recovery bit and RX threshold, written in the ack cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rec_q  <= 1'b0;
      thld_q <= '0;
    end else if (wr_ack) begin
      if (adr == tti_csr_pkg::CsrCtrl) begin
        rec_q <= wb_dat_i[tti_csr_pkg::CtrlRecBit];
      end
      if (adr == tti_csr_pkg::CsrThld) begin
        thld_q <= wb_dat_i[tti_csr_pkg::ThldLsb +: tti_pkg::ThldWidth];
      end
    end
  end

  assign rec_en_o = rec_q;

  // Queue side effects happen in the ack cycle
  // In recovery TX writes are dropped and RX reads leave the queue alone
  assign tx_push_o  = wr_ack && (adr == tti_csr_pkg::CsrTxData) && !rec_q;
  assign tx_wdata_o = wb_dat_i;
  assign rx_pop_o   = rd_ack && (adr == tti_csr_pkg::CsrRxData) && !rec_q;

  assign tx_flush_o = wr_ack && (adr == tti_csr_pkg::CsrCtrl)
                      && wb_dat_i[tti_csr_pkg::CtrlTxFlushBit];
  assign rx_flush_o = wr_ack && (adr == tti_csr_pkg::CsrCtrl)
                      && wb_dat_i[tti_csr_pkg::CtrlRxFlushBit];

  // Readback words
  always_comb begin
    status_word = '0;
    status_word[tti_csr_pkg::StatRxEmptyBit] = rx_empty;
    status_word[tti_csr_pkg::StatRxFullBit]  = rx_full;
    status_word[tti_csr_pkg::StatTxEmptyBit] = tx_empty;
    status_word[tti_csr_pkg::StatTxFullBit]  = tx_full;
    status_word[tti_csr_pkg::StatRxCntLsb +: $bits(tti_pkg::count_t)] = rx_count_i;
    status_word[tti_csr_pkg::StatTxCntLsb +: $bits(tti_pkg::count_t)] = tx_count_i;

    // Flush bits always read as zero
    ctrl_word = '0;
    ctrl_word[tti_csr_pkg::CtrlRecBit] = rec_q;

    thld_word = '0;
    thld_word[tti_csr_pkg::ThldLsb +: tti_pkg::ThldWidth] = thld_q;
  end

  // Read data mux, only driven during a read ack
  always_comb begin
    wb_dat_o = '0;
    if (rd_ack) begin
      case (adr)
        tti_csr_pkg::CsrRxData: begin
          if (!rec_q && !rx_empty) begin
            wb_dat_o = rx_rdata_i;
          end
        end
        tti_csr_pkg::CsrCtrl:   wb_dat_o = ctrl_word;
        tti_csr_pkg::CsrThld:   wb_dat_o = thld_word;
        tti_csr_pkg::CsrStatus: wb_dat_o = status_word;
        default:                wb_dat_o = '0;
      endcase
    end
  end

  // RX ready interrupt, disabled by a zero threshold
  assign irq_o = (thld_q != '0) && (rx_count_i >= tti_pkg::count_t'(thld_q));

endmodule

`default_nettype wire

// ==== recovery_handler.sv ====
// Recovery queue switch top level with the Wishbone CSR slave and the RX and TX data queues
`timescale 1ns/100ps
`default_nettype none

module recovery_handler #(
  parameter int unsigned Depth = tti_pkg::Depth
) (
  input  logic                              clk_i,
  input  logic                              rst_i,

  // Software side, Wishbone classic
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  logic [tti_csr_pkg::AdrWidth-1:0]  wb_adr_i,
  input  tti_pkg::data_t                    wb_dat_i,
  output tti_pkg::data_t                    wb_dat_o,
  output logic                              wb_ack_o,

  // Controller side, RX push
  input  logic                              ctl_rx_wvalid_i,
  output logic                              ctl_rx_wready_o,
  input  tti_pkg::data_t                    ctl_rx_wdata_i,
  output logic                              ctl_rx_full_o,

  // Controller side, TX pop
  output logic                              ctl_tx_rvalid_o,
  input  logic                              ctl_tx_rready_i,
  output tti_pkg::data_t                    ctl_tx_rdata_o,
  output logic                              ctl_tx_empty_o,

  output logic                              irq_o
);

  logic            rec_en;

  logic            rx_pop;
  logic            rx_flush;
  tti_pkg::data_t  rx_rdata;
  tti_pkg::count_t rx_count;

  logic            tx_push;
  logic            tx_flush;
  tti_pkg::data_t  tx_wdata;
  tti_pkg::count_t tx_count;

  tti_csr_wb #(
    .Depth (Depth)
  ) u_csr (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .rx_rdata_i (rx_rdata),
    .rx_count_i (rx_count),
    .rx_pop_o   (rx_pop),
    .rx_flush_o (rx_flush),
    .tx_count_i (tx_count),
    .tx_push_o  (tx_push),
    .tx_wdata_o (tx_wdata),
    .tx_flush_o (tx_flush),
    .rec_en_o   (rec_en),
    .irq_o      (irq_o)
  );

  // Controller writes, software reads
  tti_fifo #(
    .Depth      (Depth),
    .CtlOnWrite (1'b1)
  ) u_rx_queue (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .flush_i  (rx_flush),
    .ctl_en_i (rec_en),
    .push_i   (ctl_rx_wvalid_i),
    .wdata_i  (ctl_rx_wdata_i),
    .wready_o (ctl_rx_wready_o),
    .pop_i    (rx_pop),
    .rvalid_o (),
    .rdata_o  (rx_rdata),
    .full_o   (ctl_rx_full_o),
    .empty_o  (),
    .count_o  (rx_count)
  );

  // Software writes, controller reads
  tti_fifo #(
    .Depth      (Depth),
    .CtlOnWrite (1'b0)
  ) u_tx_queue (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .flush_i  (tx_flush),
    .ctl_en_i (rec_en),
    .push_i   (tx_push),
    .wdata_i  (tx_wdata),
    .wready_o (),
    .pop_i    (ctl_tx_rready_i),
    .rvalid_o (ctl_tx_rvalid_o),
    .rdata_o  (ctl_tx_rdata_o),
    .full_o   (),
    .empty_o  (ctl_tx_empty_o),
    .count_o  (tx_count)
  );

endmodule

`default_nettype wire

// ==== recovery_handler_props.sv ====
// Concurrent Wishbone and controller port assertions bound to the recovery queue switch
`timescale 1ns/100ps
`default_nettype none

module recovery_handler_props (
  input logic clk_i,
  input logic rst_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic rx_wready_i,
  input logic rx_full_i,
  input logic tx_rvalid_i,
  input logic rec_en_i
);

  int unsigned fail_count = 0;

  ack_in_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_i |-> (wb_cyc_i && wb_stb_i))
    else begin
      fail_count++;
      $error("Wishbone ack high outside an active request");
    end

  // Ack lasts exactly one cycle
  ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
    !(wb_ack_i && $past(wb_ack_i)))
    else begin
      fail_count++;
      $error("Wishbone ack high on two cycles in a row");
    end

  rx_ready_not_full: assert property (@(posedge clk_i) disable iff (rst_i)
    !(rx_wready_i && rx_full_i))
    else begin
      fail_count++;
      $error("RX queue shows ready while full");
    end

  rec_blocks_ctl: assert property (@(posedge clk_i) disable iff (rst_i)
    rec_en_i |-> (!rx_wready_i && !tx_rvalid_i))
    else begin
      fail_count++;
      $error("Controller port active while recovery is on");
    end

endmodule

bind recovery_handler recovery_handler_props u_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .wb_cyc_i    (wb_cyc_i),
  .wb_stb_i    (wb_stb_i),
  .wb_ack_i    (wb_ack_o),
  .rx_wready_i (ctl_rx_wready_o),
  .rx_full_i   (ctl_rx_full_o),
  .tx_rvalid_i (ctl_tx_rvalid_o),
  .rec_en_i    (rec_en)
);

`default_nettype wire

// ==== tb_recovery_handler.sv ====
// Testbench with xorshift stimulus, queue reference model, compare tasks, timeout and verdict
`timescale 1ns/100ps
`default_nettype none

module tb_recovery_handler;

  localparam int Depth = 8;
  localparam int TimeoutCycles = 4000;
  localparam int CntBits = $bits(tti_pkg::count_t);
  localparam logic [31:0] Seed = 32'h3d4b;
  localparam tti_pkg::data_t RecOn = tti_pkg::data_t'(1 << tti_csr_pkg::CtrlRecBit);
  localparam tti_pkg::data_t FlushBoth =
    tti_pkg::data_t'((1 << tti_csr_pkg::CtrlTxFlushBit) | (1 << tti_csr_pkg::CtrlRxFlushBit));

  logic clk_i = 1'b0;
  logic rst_i;
  logic wb_cyc_i, wb_stb_i, wb_we_i, wb_ack_o;
  logic [tti_csr_pkg::AdrWidth-1:0] wb_adr_i;
  tti_pkg::data_t wb_dat_i, wb_dat_o, ctl_tx_rdata_o;
  logic ctl_rx_wvalid_i = 1'b0;
  tti_pkg::data_t ctl_rx_wdata_i = '0;
  logic ctl_tx_rready_i = 1'b0;
  logic ctl_rx_wready_o, ctl_rx_full_o, ctl_tx_rvalid_o, ctl_tx_empty_o, irq_o;

  // Reference model, fed only by handshakes seen at the ports
  tti_pkg::data_t rx_q[$];
  tti_pkg::data_t tx_q[$];
  logic           rec_m = 1'b0;
  tti_pkg::thld_t thld_m = '0;

  logic [31:0] seed = Seed;
  logic [31:0] ctl_seed = {Seed[15:0], Seed[31:16]};
  int rx_target = 0;
  int rx_sent = 0;
  int tx_mode = 0;  // 0 rready low, 1 random, 2 always high
  int cycles = 0;
  int word_errs = 0, count_errs = 0, bit_errs = 0, other_errs = 0;

  recovery_handler #(.Depth(Depth)) dut0 (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    seed = xorshift32(seed);
    return seed;
  endfunction

  task automatic check_word(input string name, input tti_pkg::data_t exp,
                            input tti_pkg::data_t act);
    if (act !== exp) begin
      word_errs++;
      $display("[ERROR] %s: expected %h, actual %h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_count(input string name, input tti_pkg::count_t exp,
                             input tti_pkg::count_t act);
    if (act !== exp) begin
      count_errs++;
      $display("[ERROR] %s: expected %0d, actual %0d at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      bit_errs++;
      $display("[ERROR] %s: expected %b, actual %b at %0t", name, exp, act, $time);
    end
  endtask

  task automatic check_status();
    check_count("status_rx_count", tti_pkg::count_t'(rx_q.size()),
                wb_dat_o[tti_csr_pkg::StatRxCntLsb +: CntBits]);
    check_count("status_tx_count", tti_pkg::count_t'(tx_q.size()),
                wb_dat_o[tti_csr_pkg::StatTxCntLsb +: CntBits]);
    check_bit("status_rx_empty", rx_q.size() == 0, wb_dat_o[tti_csr_pkg::StatRxEmptyBit]);
    check_bit("status_rx_full", rx_q.size() == Depth, wb_dat_o[tti_csr_pkg::StatRxFullBit]);
    check_bit("status_tx_empty", tx_q.size() == 0, wb_dat_o[tti_csr_pkg::StatTxEmptyBit]);
    check_bit("status_tx_full", tx_q.size() == Depth, wb_dat_o[tti_csr_pkg::StatTxFullBit]);
  endtask

  task automatic wb_write(input tti_csr_pkg::csr_adr_e adr, input tti_pkg::data_t data);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b1;
    wb_adr_i <= adr;
    wb_dat_i <= data;
    @(negedge clk_i);
    while (!wb_ack_o) @(negedge clk_i);
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  task automatic wb_read(input tti_csr_pkg::csr_adr_e adr, output tti_pkg::data_t data);
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= 1'b0;
    wb_adr_i <= adr;
    @(negedge clk_i);
    while (!wb_ack_o) @(negedge clk_i);
    data = wb_dat_o;
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
  endtask

  task automatic queue_rx(input int n);
    @(negedge clk_i);
    rx_target = rx_target + n;
  endtask

  task automatic wait_rx();
    @(negedge clk_i);
    while (rx_sent < rx_target) @(negedge clk_i);
  endtask

  task automatic set_tx_mode(input int m);
    @(negedge clk_i);
    tx_mode = m;
  endtask

  task automatic wait_tx_empty();
    @(negedge clk_i);
    while (!ctl_tx_empty_o) @(negedge clk_i);
  endtask

  task automatic drain_rx();
    tti_pkg::data_t d;
    @(negedge clk_i);
    while (rx_q.size() > 0) begin
      wb_read(tti_csr_pkg::CsrRxData, d);
      @(negedge clk_i);
    end
    wb_read(tti_csr_pkg::CsrStatus, d);
  endtask

  // Controller side: RX pushes with random gaps, TX rready by mode
  always @(posedge clk_i) begin : ctl_driver
    if (!rst_i && ctl_rx_wvalid_i && ctl_rx_wready_o) begin
      rx_sent = rx_sent + 1;
    end
    ctl_seed = xorshift32(ctl_seed);
    if (!ctl_rx_wvalid_i || ctl_rx_wready_o) begin
      ctl_rx_wvalid_i <= (rx_sent < rx_target) && ctl_seed[3];
      ctl_rx_wdata_i  <= ctl_seed;
    end
    ctl_tx_rready_i <= (tx_mode == 2) || ((tx_mode == 1) && ctl_seed[7]);
  end

  // Compares first, then applies this edge's handshakes to the model
  always @(posedge clk_i) begin : model_monitor
    tti_csr_pkg::csr_adr_e adr;
    tti_pkg::data_t exp;
    adr = tti_csr_pkg::csr_adr_e'(wb_adr_i);
    if (!rst_i) begin
      check_bit("irq", (thld_m != '0) && (rx_q.size() >= int'(thld_m)), irq_o);
      // Controller port flags follow the model levels and drop in recovery
      check_bit("ctl_rx_wready", !rec_m && (rx_q.size() < Depth), ctl_rx_wready_o);
      check_bit("ctl_rx_full", !rec_m && (rx_q.size() == Depth), ctl_rx_full_o);
      check_bit("ctl_tx_rvalid", !rec_m && (tx_q.size() > 0), ctl_tx_rvalid_o);
      check_bit("ctl_tx_empty", !rec_m && (tx_q.size() == 0), ctl_tx_empty_o);
      if (wb_ack_o && !wb_we_i) begin
        case (adr)
          tti_csr_pkg::CsrRxData: begin
            exp = '0;
            if (!rec_m && rx_q.size() > 0) begin
              exp = rx_q[0];
              rx_q.delete(0);
            end
            check_word("rx_read", exp, wb_dat_o);
          end
          tti_csr_pkg::CsrCtrl:   check_word("ctrl_readback", tti_pkg::data_t'(rec_m), wb_dat_o);
          tti_csr_pkg::CsrThld:   check_word("thld_readback", tti_pkg::data_t'(thld_m), wb_dat_o);
          tti_csr_pkg::CsrStatus: check_status();
          default:                check_word("unmapped_read", '0, wb_dat_o);
        endcase
      end
      if (ctl_tx_rvalid_o && ctl_tx_rready_i) begin
        if (tx_q.size() == 0) begin
          other_errs++;
          $display("Controller popped a TX word that was never written, at %0t", $time);
        end else begin
          check_word("tx_pop", tx_q[0], ctl_tx_rdata_o);
          tx_q.delete(0);
        end
      end
      if (ctl_rx_wvalid_i && ctl_rx_wready_o) begin
        rx_q.push_back(ctl_rx_wdata_i);
      end
      if (wb_ack_o && wb_we_i) begin
        if (adr == tti_csr_pkg::CsrTxData && !rec_m) begin
          tx_q.push_back(wb_dat_i);
        end
        if (adr == tti_csr_pkg::CsrCtrl) begin
          if (wb_dat_i[tti_csr_pkg::CtrlTxFlushBit]) tx_q.delete();
          if (wb_dat_i[tti_csr_pkg::CtrlRxFlushBit]) rx_q.delete();
          rec_m = wb_dat_i[tti_csr_pkg::CtrlRecBit];
        end
        if (adr == tti_csr_pkg::CsrThld) begin
          thld_m = wb_dat_i[tti_csr_pkg::ThldLsb +: tti_pkg::ThldWidth];
        end
      end
    end
  end

  always @(posedge clk_i) begin : watchdog
    cycles++;
    if (cycles >= TimeoutCycles) begin
      $display("Run stopped after %0d cycles, a handshake never completed", cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin : stimulus
    tti_pkg::data_t rd;
    tti_pkg::thld_t thld;
    int k, left, total;
    rst_i <= 1'b1;
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    wb_adr_i <= '0;
    wb_dat_i <= '0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    check_bit("reset_ack", 1'b0, wb_ack_o);
    check_bit("reset_rx_wready", 1'b1, ctl_rx_wready_o);
    check_bit("reset_tx_rvalid", 1'b0, ctl_tx_rvalid_o);
    check_bit("reset_irq", 1'b0, irq_o);

    // RX path in rounds, one extra read hits the empty queue
    left = 40;
    while (left > 0) begin
      k = 1 + int'(next_rand() & 32'd7);
      if (k > left) k = left;
      queue_rx(k);
      wait_rx();
      left = left - k;
      repeat (k + 1) begin
        wb_read(tti_csr_pkg::CsrRxData, rd);
        wb_read(tti_csr_pkg::CsrStatus, rd);
      end
    end

    // TX path with random rready, then a write into a full queue
    set_tx_mode(1);
    repeat (20) begin
      wb_write(tti_csr_pkg::CsrTxData, next_rand());
      wb_read(tti_csr_pkg::CsrStatus, rd);
    end
    set_tx_mode(2);
    wait_tx_empty();
    set_tx_mode(0);
    repeat (Depth) wb_write(tti_csr_pkg::CsrTxData, next_rand());
    wb_read(tti_csr_pkg::CsrStatus, rd);
    fork
      wb_write(tti_csr_pkg::CsrTxData, next_rand());
      begin
        repeat (6) begin
          @(negedge clk_i);
          check_bit("tx_full_ack_held", 1'b0, wb_ack_o);
        end
        set_tx_mode(2);
      end
    join
    wait_tx_empty();
    set_tx_mode(0);

    // Random thresholds, the first one zero
    for (int i = 0; i < 6; i++) begin
      thld = (i == 0) ? '0 : tti_pkg::thld_t'(next_rand() & 32'd7);
      wb_write(tti_csr_pkg::CsrThld, tti_pkg::data_t'(thld));
      wb_read(tti_csr_pkg::CsrThld, rd);
      queue_rx(1 + int'(next_rand() & 32'd7));
      wait_rx();
      wb_read(tti_csr_pkg::CsrStatus, rd);
      drain_rx();
    end

    // Recovery keeps both queues and blocks the controller
    queue_rx(3);
    wait_rx();
    repeat (3) wb_write(tti_csr_pkg::CsrTxData, next_rand());
    wb_write(tti_csr_pkg::CsrCtrl, RecOn);
    queue_rx(2);
    set_tx_mode(2);
    repeat (2) begin
      wb_write(tti_csr_pkg::CsrTxData, next_rand());
      wb_read(tti_csr_pkg::CsrRxData, rd);
      wb_read(tti_csr_pkg::CsrStatus, rd);
    end
    @(negedge clk_i);
    check_bit("rec_rx_wready", 1'b0, ctl_rx_wready_o);
    check_bit("rec_tx_rvalid", 1'b0, ctl_tx_rvalid_o);
    check_bit("rec_rx_full", 1'b0, ctl_rx_full_o);
    check_bit("rec_tx_empty", 1'b0, ctl_tx_empty_o);
    wb_write(tti_csr_pkg::CsrCtrl, '0);
    wait_rx();
    wait_tx_empty();
    set_tx_mode(0);
    drain_rx();

    // Flush with recovery off, then with recovery on
    queue_rx(5);
    wait_rx();
    repeat (3) wb_write(tti_csr_pkg::CsrTxData, next_rand());
    wb_write(tti_csr_pkg::CsrCtrl, FlushBoth);
    wb_read(tti_csr_pkg::CsrCtrl, rd);
    wb_read(tti_csr_pkg::CsrStatus, rd);
    queue_rx(2);
    wait_rx();
    repeat (2) wb_write(tti_csr_pkg::CsrTxData, next_rand());
    wb_write(tti_csr_pkg::CsrCtrl, FlushBoth | RecOn);
    wb_read(tti_csr_pkg::CsrCtrl, rd);
    wb_read(tti_csr_pkg::CsrStatus, rd);
    wb_write(tti_csr_pkg::CsrCtrl, '0);
    wb_read(tti_csr_pkg::CsrStatus, rd);

    total = word_errs + count_errs + bit_errs + other_errs + int'(dut0.u_props.fail_count);
    $display("Errors: word %0d, count %0d, bit %0d, other %0d, assertion %0d",
             word_errs, count_errs, bit_errs, other_errs, dut0.u_props.fail_count);
    if (total == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
tti_pkg.sv
tti_csr_pkg.sv
tti_fifo.sv
tti_csr_wb.sv
recovery_handler.sv
recovery_handler_props.sv
tb_recovery_handler.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_recovery_handler
FILELIST  := build.f
OBJDIR    := obj_dir
BIN       := $(OBJDIR)/V$(TOP)
PASS_MSG  := Test passed

.PHONY: all run lint clean

all: run

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
